// ==== source/rv_core_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Shared memory depth in words and its index width
`define RV_MEM_WORDS 1024
`define RV_MEM_AW 10

`endif

// ==== source/rf32x32.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rf32x32 (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_wr_en,
    input  logic [4:0]         i_wr_addr,
    input  logic [`RV_XLEN-1:0] i_wr_data,
    input  logic [4:0]         i_rd1_addr,
    input  logic [4:0]         i_rd2_addr,
    output logic [`RV_XLEN-1:0] o_rd1_data,
    output logic [`RV_XLEN-1:0] o_rd2_data
);

    logic [`RV_XLEN-1:0] regs [32];

    // x0 is never written so it stays at zero
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != 5'd0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rd1_data = regs[i_rd1_addr];
    assign o_rd2_data = regs[i_rd2_addr];

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // Same encoding as the low funct3 bits of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        WORD = 2'b10
    } size_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_form_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_form_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_form_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_form_t;

    // Also covers the U format, the raw upper bits are the same word
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } uj_form_t;

    typedef union packed {
        r_form_t  r_form;
        i_form_t  i_form;
        s_form_t  s_form;
        b_form_t  b_form;
        uj_form_t uj_form;
    } instr_t;

endpackage

// ==== source/ex_stage.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module ex_stage (
    input  rv_core_pkg::instr_t i_instr,
    input  logic [`RV_XLEN-1:0] i_pc,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    input  logic                i_wb_fwd_en,
    input  logic [4:0]          i_wb_fwd_rd,
    input  logic [`RV_XLEN-1:0] i_wb_fwd_data,
    output logic [4:0]          o_rs1_addr,
    output logic [4:0]          o_rs2_addr,
    output logic [`RV_XLEN-1:0] o_result,
    output logic [`RV_XLEN-1:0] o_store_data,
    output logic [4:0]          o_rd,
    output logic                o_rd_wr,
    output logic                o_is_load,
    output logic                o_is_store,
    output rv_core_pkg::size_e  o_size,
    output logic                o_branch_taken,
    output logic [`RV_XLEN-1:0] o_target
);

    rv_core_pkg::opcode_e opcode;
    logic [2:0]           funct3;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 rd_wr;
    logic [`RV_XLEN-1:0]  imm_i;
    logic [`RV_XLEN-1:0]  imm_s;
    logic [`RV_XLEN-1:0]  imm_b;
    logic [`RV_XLEN-1:0]  imm_j;
    logic [`RV_XLEN-1:0]  imm_u;
    logic [`RV_XLEN-1:0]  op_a;
    logic [`RV_XLEN-1:0]  op_b;

    assign opcode = i_instr.r_form.opcode;
    assign funct3 = i_instr.r_form.funct3;
    assign o_rd   = i_instr.r_form.rd;

    assign imm_i = {{20{i_instr.i_form.imm_11_0[11]}}, i_instr.i_form.imm_11_0};
    assign imm_s = {{20{i_instr.s_form.imm_11_5[6]}}, i_instr.s_form.imm_11_5,
                    i_instr.s_form.imm_4_0};
    assign imm_b = {{20{i_instr.b_form.imm_12}}, i_instr.b_form.imm_11,
                    i_instr.b_form.imm_10_5, i_instr.b_form.imm_4_1, 1'b0};
    assign imm_j = {{12{i_instr.uj_form.imm_20}}, i_instr.uj_form.imm_19_12,
                    i_instr.uj_form.imm_11, i_instr.uj_form.imm_10_1, 1'b0};
    assign imm_u = {i_instr.uj_form.imm_20, i_instr.uj_form.imm_10_1,
                    i_instr.uj_form.imm_11, i_instr.uj_form.imm_19_12, 12'b0};

    // Unused source fields read as x0 so they never cause a load-use stall
    assign use_rs1 = (opcode == rv_core_pkg::OP) || (opcode == rv_core_pkg::OP_IMM) ||
                     (opcode == rv_core_pkg::LOAD) || (opcode == rv_core_pkg::STORE) ||
                     (opcode == rv_core_pkg::BRANCH);
    assign use_rs2 = (opcode == rv_core_pkg::OP) || (opcode == rv_core_pkg::STORE) ||
                     (opcode == rv_core_pkg::BRANCH);

    assign o_rs1_addr = use_rs1 ? i_instr.r_form.rs1 : 5'd0;
    assign o_rs2_addr = use_rs2 ? i_instr.r_form.rs2 : 5'd0;

    // Writeback forwarding, the enable already excludes x0
    assign op_a = (i_wb_fwd_en && (i_wb_fwd_rd == o_rs1_addr)) ? i_wb_fwd_data : i_rs1_data;
    assign op_b = (i_wb_fwd_en && (i_wb_fwd_rd == o_rs2_addr)) ? i_wb_fwd_data : i_rs2_data;

    assign o_store_data = op_b;
    assign o_rd_wr      = rd_wr && (o_rd != 5'd0);

    always_comb begin
        o_result       = '0;
        rd_wr          = 1'b0;
        o_is_load      = 1'b0;
        o_is_store     = 1'b0;
        o_size         = rv_core_pkg::WORD;
        o_branch_taken = 1'b0;
        o_target       = i_pc + imm_b;
        case (opcode)
            rv_core_pkg::OP: begin
                rd_wr = 1'b1;
                case (funct3)
                    3'b000: o_result = i_instr.r_form.funct7[5] ? op_a - op_b : op_a + op_b;
                    3'b100: o_result = op_a ^ op_b;
                    3'b110: o_result = op_a | op_b;
                    3'b111: o_result = op_a & op_b;
                    default: rd_wr = 1'b0;
                endcase
            end
            rv_core_pkg::OP_IMM: begin
                // ADDI only
                rd_wr    = (funct3 == 3'b000);
                o_result = op_a + imm_i;
            end
            rv_core_pkg::LUI: begin
                rd_wr    = 1'b1;
                o_result = imm_u;
            end
            rv_core_pkg::LOAD: begin
                o_is_load = (funct3 == 3'b010) || (funct3 == 3'b100);
                rd_wr     = o_is_load;
                o_result  = op_a + imm_i;
                o_size    = (funct3 == 3'b100) ? rv_core_pkg::BYTE : rv_core_pkg::WORD;
            end
            rv_core_pkg::STORE: begin
                o_is_store = (funct3 == 3'b000) || (funct3 == 3'b010);
                o_result   = op_a + imm_s;
                o_size     = (funct3 == 3'b000) ? rv_core_pkg::BYTE : rv_core_pkg::WORD;
            end
            rv_core_pkg::BRANCH: begin
                if (funct3 == 3'b000) begin
                    o_branch_taken = (op_a == op_b);
                end else if (funct3 == 3'b001) begin
                    o_branch_taken = (op_a != op_b);
                end
            end
            rv_core_pkg::JAL: begin
                rd_wr          = 1'b1;
                o_result       = i_pc + `RV_XLEN'd4;
                o_branch_taken = 1'b1;
                o_target       = i_pc + imm_j;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_core (
    input  logic                i_clk,
    input  logic                i_rst_n,
    output logic [`RV_XLEN-1:0] o_iad,
    input  logic [`RV_XLEN-1:0] i_idt,
    input  logic                i_acki_n,
    output logic [`RV_XLEN-1:0] o_dad,
    output logic [`RV_XLEN-1:0] o_ddt_wr,
    input  logic [`RV_XLEN-1:0] i_ddt_rd,
    output logic                o_mreq,
    output logic                o_write,
    output rv_core_pkg::size_e  o_size,
    input  logic                i_ackd_n,
    output logic                o_wb_valid,
    output logic [4:0]          o_wb_rd,
    output logic [`RV_XLEN-1:0] o_wb_data
);

    logic [`RV_XLEN-1:0] pc;
    rv_core_pkg::instr_t fe_instr;
    logic [`RV_XLEN-1:0] fe_pc;

    logic [4:0]          ex_rs1_addr;
    logic [4:0]          ex_rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] ex_result;
    logic [`RV_XLEN-1:0] ex_store_data;
    logic [4:0]          ex_rd;
    logic                ex_rd_wr;
    logic                ex_is_load;
    logic                ex_is_store;
    rv_core_pkg::size_e  ex_size;
    logic                ex_branch_taken;
    logic [`RV_XLEN-1:0] ex_target;

    logic                mw_rd_wr;
    logic                mw_is_load;
    logic                mw_is_store;
    rv_core_pkg::size_e  mw_size;
    logic [4:0]          mw_rd;
    logic [`RV_XLEN-1:0] mw_result;
    logic [`RV_XLEN-1:0] mw_store_data;

    logic                freeze;
    logic                stall;
    logic                take;
    logic [7:0]          load_byte;

    // Data access not yet acknowledged holds everything
    assign freeze = o_mreq & i_ackd_n;

    // Load data is not forwarded, the consumer waits a cycle for the RF
    assign stall = mw_is_load & mw_rd_wr &
                   ((ex_rs1_addr == mw_rd) || (ex_rs2_addr == mw_rd));
    assign take  = ex_branch_taken & ~stall;

    assign o_iad = pc;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc          <= `RV_RESET_PC;
            fe_instr    <= '0;
            mw_rd_wr    <= 1'b0;
            mw_is_load  <= 1'b0;
            mw_is_store <= 1'b0;
        end else if (!freeze) begin
            if (take) begin
                pc       <= ex_target;
                fe_instr <= '0;
            end else if (!stall) begin
                if (!i_acki_n) begin
                    pc <= pc + `RV_XLEN'd4;
                end
                // All-zero word decodes as a no-op bubble
                fe_instr <= i_acki_n ? '0 : i_idt;
            end
            mw_rd_wr    <= ex_rd_wr & ~stall;
            mw_is_load  <= ex_is_load & ~stall;
            mw_is_store <= ex_is_store & ~stall;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!freeze) begin
            if (!stall && !i_acki_n) begin
                fe_pc <= pc;
            end
            mw_size       <= ex_size;
            mw_rd         <= ex_rd;
            mw_result     <= ex_result;
            mw_store_data <= ex_store_data;
        end
    end

    ex_stage ex_stage_i (
        .i_instr        (fe_instr),
        .i_pc           (fe_pc),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_wb_fwd_en    (mw_rd_wr & ~mw_is_load),
        .i_wb_fwd_rd    (mw_rd),
        .i_wb_fwd_data  (mw_result),
        .o_rs1_addr     (ex_rs1_addr),
        .o_rs2_addr     (ex_rs2_addr),
        .o_result       (ex_result),
        .o_store_data   (ex_store_data),
        .o_rd           (ex_rd),
        .o_rd_wr        (ex_rd_wr),
        .o_is_load      (ex_is_load),
        .o_is_store     (ex_is_store),
        .o_size         (ex_size),
        .o_branch_taken (ex_branch_taken),
        .o_target       (ex_target)
    );

    // Memory/writeback stage
    assign o_mreq   = mw_is_load | mw_is_store;
    assign o_write  = mw_is_store;
    assign o_size   = mw_size;
    assign o_dad    = mw_result;
    assign o_ddt_wr = (mw_size == rv_core_pkg::BYTE) ? {4{mw_store_data[7:0]}} : mw_store_data;

    always_comb begin
        case (mw_result[1:0])
            2'd0: load_byte = i_ddt_rd[7:0];
            2'd1: load_byte = i_ddt_rd[15:8];
            2'd2: load_byte = i_ddt_rd[23:16];
            default: load_byte = i_ddt_rd[31:24];
        endcase
    end

    assign o_wb_valid = mw_rd_wr & ~freeze;
    assign o_wb_rd    = mw_rd;
    assign o_wb_data  = !mw_is_load ? mw_result :
                        (mw_size == rv_core_pkg::BYTE) ? {{(`RV_XLEN-8){1'b0}}, load_byte} :
                        i_ddt_rd;

    rf32x32 rf32x32_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (o_wb_valid),
        .i_wr_addr  (mw_rd),
        .i_wr_data  (o_wb_data),
        .i_rd1_addr (ex_rs1_addr),
        .i_rd2_addr (ex_rs2_addr),
        .o_rd1_data (rs1_data),
        .o_rd2_data (rs2_data)
    );

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module mem_arbiter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_load_en,
    input  logic [`RV_MEM_AW-1:0] i_load_addr,
    input  logic [`RV_XLEN-1:0]   i_load_data,
    input  logic [`RV_XLEN-1:0]   i_dad,
    input  logic [`RV_XLEN-1:0]   i_ddt_wr,
    input  logic                  i_mreq,
    input  logic                  i_write,
    input  rv_core_pkg::size_e    i_size,
    input  logic [`RV_XLEN-1:0]   i_iad,
    input  logic [`RV_XLEN-1:0]   i_mem_rdata,
    output logic                  o_acki_n,
    output logic                  o_ackd_n,
    output logic [`RV_XLEN-1:0]   o_idt,
    output logic [`RV_XLEN-1:0]   o_ddt_rd,
    output logic [`RV_MEM_AW-1:0] o_mem_addr,
    output logic [`RV_XLEN-1:0]   o_mem_wdata,
    output logic [3:0]            o_mem_be,
    output logic                  o_mem_we
);

    logic fetch_en;
    logic gnt_data;
    logic gnt_fetch;

    // Fetch starts on the first edge after reset release
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // Loader, then data, then fetch
    assign gnt_data  = ~i_load_en & i_mreq;
    assign gnt_fetch = ~i_load_en & ~i_mreq & fetch_en;

    assign o_ackd_n = ~gnt_data;
    assign o_acki_n = ~gnt_fetch;
    assign o_idt    = i_mem_rdata;
    assign o_ddt_rd = i_mem_rdata;

    always_comb begin
        if (i_load_en) begin
            o_mem_addr  = i_load_addr;
            o_mem_wdata = i_load_data;
            o_mem_be    = 4'b1111;
            o_mem_we    = 1'b1;
        end else if (i_mreq) begin
            o_mem_addr  = i_dad[`RV_MEM_AW+1:2];
            o_mem_wdata = i_ddt_wr;
            o_mem_be    = (i_size == rv_core_pkg::BYTE) ? 4'b0001 << i_dad[1:0] : 4'b1111;
            o_mem_we    = i_write;
        end else begin
            o_mem_addr  = i_iad[`RV_MEM_AW+1:2];
            o_mem_wdata = '0;
            o_mem_be    = 4'b0000;
            o_mem_we    = 1'b0;
        end
    end

endmodule

// ==== source/unified_mem.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module unified_mem (
    input  logic                  i_clk,
    input  logic [`RV_MEM_AW-1:0] i_addr,
    input  logic [`RV_XLEN-1:0]   i_wdata,
    input  logic [3:0]            i_be,
    input  logic                  i_we,
    output logic [`RV_XLEN-1:0]   o_rdata
);

    logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];

    // Byte lane writes
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_be[b]) begin
                    mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign o_rdata = mem[i_addr];

endmodule

// ==== source/rv_soc_top.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_soc_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_load_en,
    input  logic [`RV_MEM_AW-1:0] i_load_addr,
    input  logic [`RV_XLEN-1:0]   i_load_data,
    output logic                  o_wb_valid,
    output logic [4:0]            o_wb_rd,
    output logic [`RV_XLEN-1:0]   o_wb_data
);

    // Instruction bus
    logic [`RV_XLEN-1:0]   iad;
    logic [`RV_XLEN-1:0]   idt;
    logic                  acki_n;

    // Data bus
    logic [`RV_XLEN-1:0]   dad;
    logic [`RV_XLEN-1:0]   ddt_wr;
    logic [`RV_XLEN-1:0]   ddt_rd;
    logic                  mreq;
    logic                  write;
    rv_core_pkg::size_e    size;
    logic                  ackd_n;

    // Memory port
    logic [`RV_MEM_AW-1:0] mem_addr;
    logic [`RV_XLEN-1:0]   mem_wdata;
    logic [`RV_XLEN-1:0]   mem_rdata;
    logic [3:0]            mem_be;
    logic                  mem_we;

    rv_core rv_core_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .o_iad      (iad),
        .i_idt      (idt),
        .i_acki_n   (acki_n),
        .o_dad      (dad),
        .o_ddt_wr   (ddt_wr),
        .i_ddt_rd   (ddt_rd),
        .o_mreq     (mreq),
        .o_write    (write),
        .o_size     (size),
        .i_ackd_n   (ackd_n),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

    mem_arbiter mem_arbiter_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_dad       (dad),
        .i_ddt_wr    (ddt_wr),
        .i_mreq      (mreq),
        .i_write     (write),
        .i_size      (size),
        .i_iad       (iad),
        .i_mem_rdata (mem_rdata),
        .o_acki_n    (acki_n),
        .o_ackd_n    (ackd_n),
        .o_idt       (idt),
        .o_ddt_rd    (ddt_rd),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_be    (mem_be),
        .o_mem_we    (mem_we)
    );

    unified_mem unified_mem_i (
        .i_clk   (i_clk),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .i_be    (mem_be),
        .i_we    (mem_we),
        .o_rdata (mem_rdata)
    );

endmodule

// ==== tb/rv_iss_model.sv ====
`include "rv_core_defines.svh"

package rv_iss_model;

    logic [31:0] mem [`RV_MEM_WORDS];
    logic [31:0] regs [32];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // Runs from address 0 until the JAL that jumps to itself
    function automatic void execute_program();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr;
        logic        done;
        pc = 32'd0;
        done = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        exp_rd.delete();
        exp_data.delete();
        for (int step = 0; (step < 4096) && !done; step++) begin
            ins  = mem[pc[`RV_MEM_AW+1:2]];
            rd   = ins[11:7];
            f3   = ins[14:12];
            a    = regs[ins[19:15]];
            b    = regs[ins[24:20]];
            next = pc + 32'd4;
            wr   = 1'b1;
            res  = 32'd0;
            case (ins[6:0])
                7'b0110011: begin
                    case (f3)
                        3'b000: res = ins[30] ? a - b : a + b;
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: res = a + {{20{ins[31]}}, ins[31:20]};
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    word = mem[addr[`RV_MEM_AW+1:2]];
                    res  = (f3 == 3'b100) ? {24'b0, word[8*addr[1:0] +: 8]} : word;
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (f3 == 3'b000) begin
                        mem[addr[`RV_MEM_AW+1:2]][8*addr[1:0] +: 8] = b[7:0];
                    end else begin
                        mem[addr[`RV_MEM_AW+1:2]] = b;
                    end
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if (((f3 == 3'b000) && (a == b)) || ((f3 == 3'b001) && (a != b))) begin
                        next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: begin
                    // JAL, link is the address after it
                    res  = pc + 32'd4;
                    next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                    done = (next == pc);
                end
            endcase
            if (wr && (rd != 5'd0)) begin
                regs[rd] = res;
                exp_rd.push_back(rd);
                exp_data.push_back(res);
            end
            pc = next;
        end
    endfunction

endpackage

// ==== tb/tb_rv_soc_top.sv ====
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module tb_rv_soc_top;

    localparam int CLK_PERIOD = 8;
    localparam int N_INSTR    = 200;
    localparam int DATA_WORDS = 8;
    localparam int DATA_BASE  = `RV_MEM_WORDS / 2;
    localparam int LOAD_WORDS = N_INSTR + DATA_WORDS;
    localparam int WATCHDOG_CYCLES = 3 + LOAD_WORDS + 10 * N_INSTR;

    logic                  clk;
    logic                  rst_n;
    logic                  load_en;
    logic [`RV_MEM_AW-1:0] load_addr;
    logic [`RV_XLEN-1:0]   load_data;
    logic                  wb_valid;
    logic [4:0]            wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;

    logic [31:0] prog [N_INSTR];
    int          seed;
    int          wb_count;
    int          n_expected;
    logic        running;

    rv_soc_top rv_soc_top_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_load_en   (load_en),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .o_wb_valid  (wb_valid),
        .o_wb_rd     (wb_rd),
        .o_wb_data   (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    function int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Data words differ in every address bit
    function automatic logic [31:0] fill_word(input int a);
        return (32'(a) * 32'h9e37_79b1) ^ {22'h2a5a5a, 10'(a)};
    endfunction

    // Sources and destinations from x0..x7 to force many hazards, x31 holds the data base
    task automatic build_program();
        logic [31:0] ins;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          kind;
        int          w;
        int          b;
        int          d;
        prog[0] = rv_iss_model::enc_u(5'd31, 20'h1);
        prog[1] = rv_iss_model::enc_i(12'h800, 5'd31, 3'b000, 5'd31, 7'b0010011);
        for (int i = 2; i < N_INSTR - 1; i++) begin
            kind = rand_below(14);
            rd   = 5'(rand_below(8));
            rs1  = 5'(rand_below(8));
            rs2  = 5'(rand_below(8));
            w    = rand_below(DATA_WORDS);
            b    = rand_below(4);
            d    = 2 + rand_below(4);
            if (i + d > N_INSTR - 1) begin
                d = N_INSTR - 1 - i;
            end
            case (kind)
                0: ins = rv_iss_model::enc_r(7'h00, rs2, rs1, 3'b000, rd);
                1: ins = rv_iss_model::enc_r(7'h20, rs2, rs1, 3'b000, rd);
                2: ins = rv_iss_model::enc_r(7'h00, rs2, rs1, 3'b111, rd);
                3: ins = rv_iss_model::enc_r(7'h00, rs2, rs1, 3'b110, rd);
                4: ins = rv_iss_model::enc_r(7'h00, rs2, rs1, 3'b100, rd);
                5: ins = rv_iss_model::enc_i(12'($random(seed)), rs1, 3'b000, rd, 7'b0010011);
                6: ins = rv_iss_model::enc_u(rd, 20'($random(seed)));
                7: ins = rv_iss_model::enc_i(12'(4 * w), 5'd31, 3'b010, rd, 7'b0000011);
                8: ins = rv_iss_model::enc_i(12'(4 * w + b), 5'd31, 3'b100, rd, 7'b0000011);
                9: ins = rv_iss_model::enc_s(12'(4 * w), rs2, 5'd31, 3'b010);
                10: ins = rv_iss_model::enc_s(12'(4 * w + b), rs2, 5'd31, 3'b000);
                11: ins = rv_iss_model::enc_b(13'(4 * d), rs2, rs1, 3'b000);
                12: ins = rv_iss_model::enc_b(13'(4 * d), rs2, rs1, 3'b001);
                default: ins = rv_iss_model::enc_j(rd, 21'(4 * d));
            endcase
            prog[i] = ins;
        end
        prog[N_INSTR - 1] = rv_iss_model::enc_j(5'd0, 21'd0);
    endtask

    task automatic load_word(input int a, input logic [31:0] data);
        load_addr = `RV_MEM_AW'(a);
        load_data = data;
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin
        if (wb_valid) begin
            if (!running) begin
                fail_run("writeback seen during reset or program load");
            end else if (wb_count >= n_expected) begin
                fail_run("writeback seen after the last expected one");
            end else begin
                check($sformatf("wb%0d_rd", wb_count),
                      {27'b0, rv_iss_model::exp_rd[wb_count]}, {27'b0, wb_rd});
                check($sformatf("wb%0d_data", wb_count),
                      rv_iss_model::exp_data[wb_count], wb_data);
                wb_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("timeout, the writeback sequence did not complete");
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_en   = 1'b1;
        load_addr = '0;
        load_data = '0;
        running   = 1'b0;
        wb_count  = 0;
        seed      = 37970;
        build_program();
        for (int i = 0; i < N_INSTR; i++) begin
            rv_iss_model::mem[i] = prog[i];
        end
        for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
            rv_iss_model::mem[i] = fill_word(i);
        end
        rv_iss_model::execute_program();
        n_expected = rv_iss_model::exp_rd.size();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Loader holds the memory, so the core only sees bubbles
        for (int i = 0; i < N_INSTR; i++) begin
            load_word(i, prog[i]);
        end
        for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
            load_word(i, fill_word(i));
        end
        load_en = 1'b0;
        running = 1'b1;
        wait (wb_count == n_expected);
        repeat (20) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/rf32x32.sv
source/rv_core_pkg.sv
source/ex_stage.sv
source/rv_core.sv
source/mem_arbiter.sv
source/unified_mem.sv
source/rv_soc_top.sv
tb/rv_iss_model.sv
tb/tb_rv_soc_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_rv_soc_top \
    -f list.f \
    -o sim_tb_rv_soc_top

./obj_dir/sim_tb_rv_soc_top
